//--- rtl/gpu_node_pkg.sv
package gpu_node_pkg;

    // Network flit and node number
    localparam int FLIT_W    = 16;
    localparam int NODE_ID_W = 6;

    // Local memory geometry
    localparam int INDEX_W    = 8;
    localparam int MEM_WORDS  = 1 << INDEX_W;
    localparam int DATA_W     = 64;
    localparam int WORD_FLITS = DATA_W / FLIT_W;

    // Header opcode, bits 9:8 of the header flit
    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_REPLY = 2'd2,
        OP_RSVD  = 2'd3
    } flit_op_e;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Destination and word of a pending network read reply
    typedef struct packed {
        logic [NODE_ID_W-1:0] node;
        logic [INDEX_W-1:0]   index;
    } reply_job_t;

endpackage

//--- rtl/mem_req_if.sv
`timescale 1ns/1ps
interface mem_req_if;
    import gpu_node_pkg::*;

    logic                req;
    logic                we;
    logic [INDEX_W-1:0]  index;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    // Grant is combinational, read data follows one cycle later
    logic                gnt;
    logic [DATA_W-1:0]   rdata;
    logic                rvalid;

    modport requester (output req, we, index, wdata, wstrb, input gnt, rdata, rvalid);
    modport responder (input req, we, index, wdata, wstrb, output gnt, rdata, rvalid);
    // Read data tap for the reply path
    modport observer (input rdata, rvalid);

endinterface

//--- rtl/flit_rx.sv
`timescale 1ns/1ps
module flit_rx #(
    parameter int NODE_ID = 24
) (
    input  logic                            ACLK,
    input  logic                            ARESETn,
    input  logic [gpu_node_pkg::FLIT_W-1:0] net_data_in,
    input  logic                            net_valid_in,
    output logic                            net_ready_out,
    mem_req_if.requester                    mem,
    output gpu_node_pkg::reply_job_t        reply_job,
    output logic                            reply_job_valid,
    input  logic                            tx_busy
);
    import gpu_node_pkg::*;

    typedef enum logic [1:0] {RX_HEADER, RX_BODY, RX_REQ, RX_WAIT_TX} rx_state_e;

    rx_state_e            state_q;
    logic [2:0]           cnt_q;
    flit_op_e             op_q;
    logic [NODE_ID_W-1:0] dest_q;
    logic [INDEX_W-1:0]   index_q;
    logic [NODE_ID_W-1:0] src_q;
    logic [DATA_W-1:0]    wdata_q;
    flit_op_e             hdr_op;
    logic                 flit_in;
    logic                 to_node;

    // Body flits after the header, by opcode
    function automatic logic [2:0] body_len(flit_op_e op);
        case (op)
            OP_READ:            return 3'd1;
            OP_WRITE, OP_REPLY: return 3'(WORD_FLITS);
            default:            return 3'd0;
        endcase
    endfunction

    assign net_ready_out = (state_q == RX_HEADER) || (state_q == RX_BODY);
    assign flit_in       = net_valid_in && net_ready_out;
    assign hdr_op        = flit_op_e'(net_data_in[9:8]);
    assign to_node       = (dest_q == NODE_ID_W'(NODE_ID));

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= RX_HEADER;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                RX_HEADER: begin
                    if (flit_in && body_len(hdr_op) != 3'd0) begin
                        cnt_q   <= body_len(hdr_op) - 3'd1;
                        state_q <= RX_BODY;
                    end
                end
                RX_BODY: begin
                    if (flit_in) begin
                        cnt_q <= cnt_q - 3'd1;
                        // Foreign packets are only counted through
                        if (cnt_q == 3'd0) begin
                            state_q <= (to_node && op_q != OP_REPLY) ? RX_REQ : RX_HEADER;
                        end
                    end
                end
                RX_REQ: begin
                    if (mem.gnt) begin
                        state_q <= (op_q == OP_READ) ? RX_WAIT_TX : RX_HEADER;
                    end
                end
                default: begin
                    if (!tx_busy) begin
                        state_q <= RX_HEADER;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (flit_in && state_q == RX_HEADER) begin
            dest_q  <= net_data_in[FLIT_W-1 -: NODE_ID_W];
            op_q    <= hdr_op;
            index_q <= net_data_in[INDEX_W-1:0];
        end
        if (flit_in && state_q == RX_BODY && to_node) begin
            // Most significant flit first
            wdata_q <= {wdata_q[DATA_W-FLIT_W-1:0], net_data_in};
            src_q   <= net_data_in[NODE_ID_W-1:0];
        end
    end

    assign mem.req   = (state_q == RX_REQ);
    assign mem.we    = (op_q == OP_WRITE);
    assign mem.index = index_q;
    assign mem.wdata = wdata_q;
    assign mem.wstrb = '1;

    assign reply_job.node  = src_q;
    assign reply_job.index = index_q;
    assign reply_job_valid = mem.req && mem.gnt && (op_q == OP_READ);

    a_no_rsvd_op: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (flit_in && state_q == RX_HEADER) |-> hdr_op != OP_RSVD);

endmodule

//--- rtl/axi_mem_port.sv
`timescale 1ns/1ps
module axi_mem_port #(
    parameter int AXI_ID_W = 4,
    parameter int ADDR_W   = 32
) (
    input  logic                              ACLK,
    input  logic                              ARESETn,
    input  logic [AXI_ID_W-1:0]               s_awid,
    input  logic [ADDR_W-1:0]                 s_awaddr,
    input  logic                              s_awvalid,
    output logic                              s_awready,
    input  logic [gpu_node_pkg::DATA_W-1:0]   s_wdata,
    input  logic [gpu_node_pkg::DATA_W/8-1:0] s_wstrb,
    input  logic                              s_wvalid,
    output logic                              s_wready,
    output logic [AXI_ID_W-1:0]               s_bid,
    output logic [1:0]                        s_bresp,
    output logic                              s_bvalid,
    input  logic                              s_bready,
    input  logic [AXI_ID_W-1:0]               s_arid,
    input  logic [ADDR_W-1:0]                 s_araddr,
    input  logic                              s_arvalid,
    output logic                              s_arready,
    output logic [AXI_ID_W-1:0]               s_rid,
    output logic [gpu_node_pkg::DATA_W-1:0]   s_rdata,
    output logic [1:0]                        s_rresp,
    output logic                              s_rvalid,
    input  logic                              s_rready,
    mem_req_if.requester                      mem
);
    import gpu_node_pkg::*;

    typedef enum logic [2:0] {
        AXI_IDLE, AXI_WR_REQ, AXI_RD_REQ, AXI_RD_WAIT, AXI_BRESP, AXI_RRESP
    } axi_state_e;

    axi_state_e          state_q;
    logic                aw_held;
    logic                w_held;
    logic                ar_held;
    logic [AXI_ID_W-1:0] aw_id_q;
    logic [AXI_ID_W-1:0] ar_id_q;
    logic [ADDR_W-1:0]   aw_addr_q;
    logic [ADDR_W-1:0]   ar_addr_q;
    logic [DATA_W-1:0]   w_data_q;
    logic [DATA_W/8-1:0] w_strb_q;
    logic [DATA_W-1:0]   r_data_q;
    logic [1:0]          resp_q;
    logic                aw_bad;
    logic                ar_bad;

    // Anything above the word range is outside the memory
    assign aw_bad = |aw_addr_q[ADDR_W-1:INDEX_W+3];
    assign ar_bad = |ar_addr_q[ADDR_W-1:INDEX_W+3];

    assign s_awready = (state_q == AXI_IDLE) && !aw_held;
    assign s_wready  = (state_q == AXI_IDLE) && !w_held;
    assign s_arready = (state_q == AXI_IDLE) && !ar_held;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= AXI_IDLE;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            ar_held <= 1'b0;
        end else begin
            aw_held <= aw_held || (s_awvalid && s_awready);
            w_held  <= w_held || (s_wvalid && s_wready);
            ar_held <= ar_held || (s_arvalid && s_arready);
            case (state_q)
                AXI_IDLE: begin
                    // Read wins when both directions are waiting
                    if (ar_held) begin
                        state_q <= ar_bad ? AXI_RRESP : AXI_RD_REQ;
                    end else if (aw_held && w_held) begin
                        state_q <= aw_bad ? AXI_BRESP : AXI_WR_REQ;
                    end
                end
                AXI_WR_REQ:  if (mem.gnt) state_q <= AXI_BRESP;
                AXI_RD_REQ:  if (mem.gnt) state_q <= AXI_RD_WAIT;
                AXI_RD_WAIT: if (mem.rvalid) state_q <= AXI_RRESP;
                AXI_BRESP: begin
                    if (s_bready) begin
                        aw_held <= 1'b0;
                        w_held  <= 1'b0;
                        state_q <= AXI_IDLE;
                    end
                end
                default: begin
                    if (s_rready) begin
                        ar_held <= 1'b0;
                        state_q <= AXI_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (s_awvalid && s_awready) begin
            aw_id_q   <= s_awid;
            aw_addr_q <= s_awaddr;
        end
        if (s_wvalid && s_wready) begin
            w_data_q <= s_wdata;
            w_strb_q <= s_wstrb;
        end
        if (s_arvalid && s_arready) begin
            ar_id_q   <= s_arid;
            ar_addr_q <= s_araddr;
        end
        if (state_q == AXI_IDLE) begin
            resp_q   <= (ar_held ? ar_bad : aw_bad) ? RESP_SLVERR : RESP_OKAY;
            // Rejected reads return zero
            r_data_q <= '0;
        end else if (state_q == AXI_RD_WAIT && mem.rvalid) begin
            r_data_q <= mem.rdata;
        end
    end

    assign s_bvalid = (state_q == AXI_BRESP);
    assign s_bid    = aw_id_q;
    assign s_bresp  = resp_q;
    assign s_rvalid = (state_q == AXI_RRESP);
    assign s_rid    = ar_id_q;
    assign s_rdata  = r_data_q;
    assign s_rresp  = resp_q;

    assign mem.req   = (state_q == AXI_WR_REQ) || (state_q == AXI_RD_REQ);
    assign mem.we    = (state_q == AXI_WR_REQ);
    // Byte address bits 10:3 pick the word
    assign mem.index = mem.we ? aw_addr_q[INDEX_W+2:3] : ar_addr_q[INDEX_W+2:3];
    assign mem.wdata = w_data_q;
    assign mem.wstrb = w_strb_q;

    a_bvalid_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_bid));
    a_rvalid_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

endmodule

//--- rtl/node_mem.sv
`timescale 1ns/1ps
module node_mem (
    input  logic         ACLK,
    input  logic         ARESETn,
    mem_req_if.responder net_port,
    mem_req_if.responder axi_port
);
    import gpu_node_pkg::*;

    logic [DATA_W-1:0]   mem_q [MEM_WORDS];
    logic [DATA_W-1:0]   rdata_q;
    logic                net_rvalid_q;
    logic                axi_rvalid_q;
    logic                acc;
    logic                acc_we;
    logic [INDEX_W-1:0]  acc_index;
    logic [DATA_W-1:0]   acc_wdata;
    logic [DATA_W/8-1:0] acc_wstrb;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    // Fixed priority, the network port wins every cycle it asks
    assign net_port.gnt = net_port.req;
    assign axi_port.gnt = axi_port.req && !net_port.req;

    assign acc       = net_port.req || axi_port.req;
    assign acc_we    = net_port.req ? net_port.we    : axi_port.we;
    assign acc_index = net_port.req ? net_port.index : axi_port.index;
    assign acc_wdata = net_port.req ? net_port.wdata : axi_port.wdata;
    assign acc_wstrb = net_port.req ? net_port.wstrb : axi_port.wstrb;

    always_ff @(posedge ACLK) begin
        if (acc && acc_we) begin
            for (int b = 0; b < DATA_W/8; b++) begin
                if (acc_wstrb[b]) begin
                    mem_q[acc_index][8*b +: 8] <= acc_wdata[8*b +: 8];
                end
            end
        end else if (acc) begin
            rdata_q <= mem_q[acc_index];
        end
    end

    // Read strobe goes back on the port that won
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            net_rvalid_q <= 1'b0;
            axi_rvalid_q <= 1'b0;
        end else begin
            net_rvalid_q <= net_port.gnt && !net_port.we;
            axi_rvalid_q <= axi_port.gnt && !axi_port.we;
        end
    end

    assign net_port.rdata  = rdata_q;
    assign net_port.rvalid = net_rvalid_q;
    assign axi_port.rdata  = rdata_q;
    assign axi_port.rvalid = axi_rvalid_q;

    // A losing AXI request waits with its fields unchanged
    a_axi_req_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
        axi_port.req && !axi_port.gnt |=>
            axi_port.req && $stable(axi_port.we) && $stable(axi_port.index));

endmodule

//--- rtl/flit_tx.sv
`timescale 1ns/1ps
module flit_tx (
    input  logic                            ACLK,
    input  logic                            ARESETn,
    mem_req_if.observer                     mem,
    input  gpu_node_pkg::reply_job_t        reply_job,
    input  logic                            reply_job_valid,
    output logic                            busy,
    output logic [gpu_node_pkg::FLIT_W-1:0] net_data_out,
    output logic                            net_valid_out,
    input  logic                            net_ready_in
);
    import gpu_node_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_WAIT_DATA, TX_SEND} tx_state_e;

    // Header plus the data flits of one word
    localparam int PKT_W = FLIT_W * (WORD_FLITS + 1);

    tx_state_e         state_q;
    logic [2:0]        left_q;
    logic [FLIT_W-1:0] hdr_q;
    logic [PKT_W-1:0]  pkt_q;
    logic              flit_out;

    assign flit_out      = net_valid_out && net_ready_in;
    assign net_valid_out = (state_q == TX_SEND);
    assign net_data_out  = pkt_q[PKT_W-1 -: FLIT_W];
    assign busy          = (state_q != TX_IDLE);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= TX_IDLE;
            left_q  <= '0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (reply_job_valid) begin
                        state_q <= TX_WAIT_DATA;
                    end
                end
                TX_WAIT_DATA: begin
                    if (mem.rvalid) begin
                        left_q  <= 3'(WORD_FLITS);
                        state_q <= TX_SEND;
                    end
                end
                default: begin
                    if (flit_out) begin
                        left_q <= left_q - 3'd1;
                        if (left_q == 3'd0) begin
                            state_q <= TX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (state_q == TX_IDLE && reply_job_valid) begin
            hdr_q <= {reply_job.node, OP_REPLY, reply_job.index};
        end
        // Word goes out most significant flit first
        if (state_q == TX_WAIT_DATA && mem.rvalid) begin
            pkt_q <= {hdr_q, mem.rdata};
        end else if (flit_out) begin
            pkt_q <= {pkt_q[PKT_W-FLIT_W-1:0], FLIT_W'(0)};
        end
    end

    a_flit_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        net_valid_out && !net_ready_in |=> net_valid_out && $stable(net_data_out));

endmodule

//--- rtl/gpu_node.sv
`timescale 1ns/1ps
module gpu_node #(
    parameter int NODE_ID  = 24,
    parameter int AXI_ID_W = 4,
    parameter int ADDR_W   = 32
) (
    input  logic                              ACLK,
    input  logic                              ARESETn,
    // Network receive side
    input  logic [gpu_node_pkg::FLIT_W-1:0]   net_data_in,
    input  logic                              net_valid_in,
    output logic                              net_ready_out,
    // Network transmit side
    output logic [gpu_node_pkg::FLIT_W-1:0]   net_data_out,
    output logic                              net_valid_out,
    input  logic                              net_ready_in,
    // AXI slave
    input  logic [AXI_ID_W-1:0]               s_awid,
    input  logic [ADDR_W-1:0]                 s_awaddr,
    input  logic                              s_awvalid,
    output logic                              s_awready,
    input  logic [gpu_node_pkg::DATA_W-1:0]   s_wdata,
    input  logic [gpu_node_pkg::DATA_W/8-1:0] s_wstrb,
    input  logic                              s_wvalid,
    output logic                              s_wready,
    output logic [AXI_ID_W-1:0]               s_bid,
    output logic [1:0]                        s_bresp,
    output logic                              s_bvalid,
    input  logic                              s_bready,
    input  logic [AXI_ID_W-1:0]               s_arid,
    input  logic [ADDR_W-1:0]                 s_araddr,
    input  logic                              s_arvalid,
    output logic                              s_arready,
    output logic [AXI_ID_W-1:0]               s_rid,
    output logic [gpu_node_pkg::DATA_W-1:0]   s_rdata,
    output logic [1:0]                        s_rresp,
    output logic                              s_rvalid,
    input  logic                              s_rready
);
    import gpu_node_pkg::*;

    reply_job_t reply_job;
    logic       reply_job_valid;
    logic       tx_busy;

    // One memory port per side, the network side also feeds the reply path
    mem_req_if net_mem ();
    mem_req_if axi_mem ();

    flit_rx #(
        .NODE_ID (NODE_ID)
    ) u_flit_rx (
        .mem (net_mem),
        .*
    );

    axi_mem_port #(
        .AXI_ID_W (AXI_ID_W),
        .ADDR_W   (ADDR_W)
    ) u_axi_mem_port (
        .mem (axi_mem),
        .*
    );

    node_mem u_node_mem (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .net_port (net_mem),
        .axi_port (axi_mem)
    );

    flit_tx u_flit_tx (
        .mem  (net_mem),
        .busy (tx_busy),
        .*
    );

endmodule

//--- dv/tb_gpu_node.sv
`timescale 1ns/1ps
module tb_gpu_node;
    import gpu_node_pkg::*;

    localparam logic [5:0] NODE = 6'd24;
    localparam int         TMO  = 200;

    logic        ACLK;
    logic        ARESETn;
    logic [15:0] net_data_in;
    logic        net_valid_in;
    logic        net_ready_out;
    logic [15:0] net_data_out;
    logic        net_valid_out;
    logic        net_ready_in;
    logic [3:0]  s_awid;
    logic [31:0] s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [63:0] s_wdata;
    logic [7:0]  s_wstrb;
    logic        s_wvalid;
    logic        s_wready;
    logic [3:0]  s_bid;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [3:0]  s_arid;
    logic [31:0] s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [3:0]  s_rid;
    logic [63:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;

    // Expected contents of the node memory
    logic [63:0] ref_mem [256];
    logic [15:0] pkt [$];
    int          n_checks;
    int          n_errors;

    gpu_node #(.NODE_ID(24), .AXI_ID_W(4), .ADDR_W(32)) dut0 (.*);

    initial begin
        ACLK = 1'b0;
        forever #20 ACLK = ~ACLK;
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        n_errors++;
        $display("Timeout: no %s within %0d cycles", what, TMO);
    endtask

    // Drive point just after the rising edge
    task automatic next_cycle();
        @(posedge ACLK);
        #2;
    endtask

    function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                                input logic [7:0] strb);
        logic [63:0] res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [15:0] header(input logic [5:0] dest, input logic [1:0] op,
                                           input logic [7:0] index);
        return {dest, op, index};
    endfunction

    function automatic logic [31:0] word_addr(input logic [7:0] index);
        return {21'd0, index, 3'd0};
    endfunction

    task automatic axi_write(input logic [3:0] id, input logic [31:0] addr,
                             input logic [63:0] data, input logic [7:0] strb);
        bit aw_done;
        bit w_done;
        bit bad;
        int n;
        aw_done   = 1'b0;
        w_done    = 1'b0;
        bad       = |addr[31:11];
        s_awid    = id;
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wstrb   = strb;
        s_wvalid  = 1'b1;
        n = 0;
        while (!(aw_done && w_done) && n < TMO) begin
            @(negedge ACLK);
            aw_done = aw_done || s_awready;
            w_done  = w_done || s_wready;
            next_cycle();
            s_awvalid = s_awvalid && !aw_done;
            s_wvalid  = s_wvalid && !w_done;
            n++;
        end
        if (!(aw_done && w_done)) begin
            s_awvalid = 1'b0;
            s_wvalid  = 1'b0;
            timed_out("AW/W handshake");
            return;
        end
        if (!bad) begin
            ref_mem[addr[10:3]] = merge_bytes(ref_mem[addr[10:3]], data, strb);
        end
        n = 0;
        do begin
            @(negedge ACLK);
            n++;
        end while (!s_bvalid && n < TMO);
        if (!s_bvalid) begin
            timed_out("write response");
        end else begin
            compare("s_bid", 64'(s_bid), 64'(id));
            compare("s_bresp", 64'(s_bresp), bad ? 64'(RESP_SLVERR) : 64'(RESP_OKAY));
        end
        next_cycle();
    endtask

    task automatic axi_read(input logic [3:0] id, input logic [31:0] addr);
        bit bad;
        int n;
        bad       = |addr[31:11];
        s_arid    = id;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge ACLK);
            n++;
        end while (!s_arready && n < TMO);
        if (!s_arready) begin
            s_arvalid = 1'b0;
            timed_out("AR handshake");
            return;
        end
        next_cycle();
        s_arvalid = 1'b0;
        n = 0;
        do begin
            @(negedge ACLK);
            n++;
        end while (!s_rvalid && n < TMO);
        if (!s_rvalid) begin
            timed_out("read data");
        end else begin
            compare("s_rid", 64'(s_rid), 64'(id));
            compare("s_rresp", 64'(s_rresp), bad ? 64'(RESP_SLVERR) : 64'(RESP_OKAY));
            compare("s_rdata", s_rdata, bad ? 64'h0 : ref_mem[addr[10:3]]);
        end
        next_cycle();
    endtask

    task automatic send_packet(input logic [15:0] flits [$]);
        int n;
        foreach (flits[i]) begin
            net_data_in  = flits[i];
            net_valid_in = 1'b1;
            n = 0;
            do begin
                @(negedge ACLK);
                n++;
            end while (!net_ready_out && n < TMO);
            if (!net_ready_out) begin
                net_valid_in = 1'b0;
                timed_out("net_ready_out");
                return;
            end
            next_cycle();
        end
        net_valid_in = 1'b0;
    endtask

    task automatic write_packet(input logic [5:0] dest, input logic [7:0] index,
                                input logic [63:0] data);
        pkt = {};
        pkt.push_back(header(dest, OP_WRITE, index));
        for (int k = 0; k < 4; k++) begin
            pkt.push_back(data[63-16*k -: 16]);
        end
        if (dest == NODE) begin
            ref_mem[index] = data;
        end
        send_packet(pkt);
    endtask

    task automatic read_packet(input logic [5:0] dest, input logic [7:0] index,
                               input logic [5:0] src);
        pkt = {};
        pkt.push_back(header(dest, OP_READ, index));
        pkt.push_back({10'd0, src});
        send_packet(pkt);
    endtask

    // Collects five reply flits while net_ready_in toggles at random
    task automatic expect_reply(input logic [5:0] dest, input logic [7:0] index,
                                input logic [63:0] word);
        logic [15:0] exp_flits [5];
        int got;
        int n;
        exp_flits[0] = header(dest, OP_REPLY, index);
        for (int k = 0; k < 4; k++) begin
            exp_flits[k+1] = word[63-16*k -: 16];
        end
        got = 0;
        n = 0;
        while (got < 5 && n < TMO) begin
            net_ready_in = ($urandom % 3) != 0;
            @(negedge ACLK);
            if (net_valid_out && net_ready_in) begin
                compare($sformatf("net_data_out flit %0d", got), 64'(net_data_out),
                        64'(exp_flits[got]));
                got++;
            end
            next_cycle();
            n++;
        end
        net_ready_in = 1'b0;
        if (got < 5) begin
            timed_out("complete reply packet");
        end
    endtask

    task automatic test_axi_rw();
        axi_write(4'h3, word_addr(8'h08), {$urandom, $urandom}, 8'hff);
        axi_read(4'h9, word_addr(8'h08));
        // Partial strobe, never all bytes
        axi_write(4'h5, word_addr(8'h08), {$urandom, $urandom}, 8'($urandom) & 8'h5a);
        axi_read(4'h6, word_addr(8'h08));
    endtask

    task automatic test_axi_range();
        axi_write(4'h1, word_addr(8'h00), {$urandom, $urandom}, 8'hff);
        // Bits 10:3 alias word 0, bit 11 puts it out of range
        axi_write(4'h2, 32'h0000_0800, {$urandom, $urandom}, 8'hff);
        axi_read(4'h4, 32'h0001_0040);
        axi_read(4'h7, word_addr(8'h00));
    endtask

    task automatic test_net_write();
        write_packet(NODE, 8'h21, {$urandom, $urandom});
        axi_read(4'hb, word_addr(8'h21));
        write_packet(6'd7, 8'h21, {$urandom, $urandom});
        read_packet(NODE, 8'h21, 6'd5);
        expect_reply(6'd5, 8'h21, ref_mem[8'h21]);
        axi_read(4'hc, word_addr(8'h21));
    endtask

    task automatic test_net_read();
        axi_write(4'h8, word_addr(8'h40), {$urandom, $urandom}, 8'hff);
        read_packet(NODE, 8'h40, 6'd5);
        expect_reply(6'd5, 8'h40, ref_mem[8'h40]);
    endtask

    task automatic test_concurrent();
        logic [63:0] wa;
        wa = {$urandom, $urandom};
        fork
            write_packet(NODE, 8'h91, {$urandom, $urandom});
            begin
                // Lines the AXI request up with the network request
                repeat (3) next_cycle();
                axi_write(4'ha, word_addr(8'h90), wa, 8'hff);
            end
        join
        axi_read(4'hd, word_addr(8'h90));
        axi_read(4'he, word_addr(8'h91));
    endtask

    initial begin
        void'($urandom(32'hd47f));
        n_checks     = 0;
        n_errors     = 0;
        ARESETn      = 1'b0;
        net_data_in  = '0;
        net_valid_in = 1'b0;
        net_ready_in = 1'b0;
        s_awid       = '0;
        s_awaddr     = '0;
        s_awvalid    = 1'b0;
        s_wdata      = '0;
        s_wstrb      = '0;
        s_wvalid     = 1'b0;
        s_bready     = 1'b1;
        s_arid       = '0;
        s_araddr     = '0;
        s_arvalid    = 1'b0;
        s_rready     = 1'b1;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = '0;
        end
        repeat (2) @(posedge ACLK);
        #2 ARESETn = 1'b1;
        next_cycle();

        test_axi_rw();
        test_axi_range();
        test_net_write();
        test_net_read();
        test_concurrent();

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/gpu_node_pkg.sv
rtl/mem_req_if.sv
rtl/flit_rx.sv
rtl/axi_mem_port.sv
rtl/node_mem.sv
rtl/flit_tx.sv
rtl/gpu_node.sv
dv/tb_gpu_node.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_gpu_node \
    -f verilog.f -o sim_gpu_node || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_gpu_node)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '=== PASS ===' && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
